/* idStage.f */
+incdir+.
idStagePkg.sv
decodeBus.sv
idPipeReg.sv
regFile.sv
instrDecoder.sv
loadUseHazard.sv
idStage.sv
idStage_tb.sv

/* Bender.yml */
package:
  name: idStage

sources:
  - idStagePkg.sv
  - decodeBus.sv
  - idPipeReg.sv
  - regFile.sv
  - instrDecoder.sv
  - loadUseHazard.sv
  - idStage.sv
  - target: test
    include_dirs:
      - .
    files:
      - idStage_tb.sv

/* idStageCases.svh */
// addRow arguments, in order
// instr, ifPc, idFlush, idWr, wbRegWrite, wbDst, wbResult, exeRt, exeIsLoad,
// expected idCtrl, expected idImm32, expected stall
// the writeback and execute fields act in the cycle the row is checked
task automatic loadCases();
    addRow(iType(OP_ADDIU, 0, 5, 16'hfff0), 32'h400, 0, 1, 1, 3, 32'h1111_0003, 0, 0,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RT, 6'b100100), 32'hffff_fff0, 0);
    addRow(rType(3, 5, 4, 0, FN_ADDU), 32'h404, 0, 1, 1, 5, 32'h0000_0055, 6, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_2021, 0);
    // write to $0 while reading it
    addRow(rType(0, 5, 6, 0, FN_SUBU), 32'h408, 0, 1, 1, 0, 32'hdead_beef, 0, 0,
           ctrlWord(ALU_SUB, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_3023, 0);
    addRow(rType(3, 0, 7, 0, FN_AND), 32'h40c, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_AND, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_3824, 0);
    addRow(rType(3, 5, 8, 0, FN_ADDU), 32'h410, 0, 1, 0, 0, 32'h0, 5, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_4021, 1);
    addRow(rType(0, 5, 9, 0, FN_OR), 32'h414, 0, 1, 0, 0, 32'h0, 0, 1,
           ctrlWord(ALU_OR, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_4825, 0);
    addRow(rType(3, 5, 10, 0, FN_SLT), 32'h418, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_SLT, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_502a, 0);
    // sll with a nonzero rs field, rs is not read
    addRow(rType(3, 5, 11, 4, FN_SLL), 32'h41c, 0, 1, 0, 0, 32'h0, 3, 1,
           ctrlWord(ALU_SLL, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_5900, 0);
    addRow(iType(OP_LUI, 0, 12, 16'h1234), 32'h420, 0, 1, 0, 0, 32'h0, 12, 1,
           ctrlWord(ALU_LUI, BR_NONE, WB_ALU, DST_RT, 6'b100100), 32'h1234_0000, 0);
    addRow(jType(OP_J, {5'd3, 5'd5, 16'h0010}), 32'h424, 0, 1, 0, 0, 32'h0, 3, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b000010), 32'h0000_0010, 0);
    addRow(jType(OP_JAL, 26'h40), 32'h428, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_ADD, BR_NONE, WB_PC8, DST_R31, 6'b100010), 32'h0000_0040, 0);
    addRow(iType(OP_ANDI, 3, 13, 16'h8001), 32'h42c, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_AND, BR_NONE, WB_ALU, DST_RT, 6'b100100), 32'h0000_8001, 0);
    addRow(iType(OP_ORI, 3, 14, 16'hf00f), 32'h430, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_OR, BR_NONE, WB_ALU, DST_RT, 6'b100100), 32'h0000_f00f, 0);
    addRow(iType(OP_LW, 3, 15, 16'hfffc), 32'h434, 0, 1, 0, 0, 32'h0, 15, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_MEM, DST_RT, 6'b110100), 32'hffff_fffc, 0);
    addRow(iType(OP_SW, 3, 5, 16'h0008), 32'h438, 0, 1, 1, 3, 32'h3333_0000, 5, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b001100), 32'h0000_0008, 1);
    addRow(iType(OP_BEQ, 3, 5, 16'hfffe), 32'h43c, 0, 1, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_SUB, BR_EQ, WB_ALU, DST_RD, 6'b000000), 32'hffff_fffe, 0);
    addRow(iType(OP_BNE, 5, 0, 16'h0003), 32'h440, 0, 1, 0, 0, 32'h0, 5, 0,
           ctrlWord(ALU_SUB, BR_NE, WB_ALU, DST_RD, 6'b000000), 32'h0000_0003, 0);
    // reserved opcode, then reserved function code
    addRow(iType(6'h3f, 3, 3, 16'h1234), 32'h444, 0, 1, 0, 0, 32'h0, 3, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b000001), 32'h0000_1234, 0);
    addRow(rType(3, 5, 16, 0, 6'h3f), 32'h448, 0, 1, 0, 0, 32'h0, 5, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b000001), 32'hffff_803f, 0);
    // idWr low, previous word stays
    addRow(iType(OP_ORI, 1, 2, 16'h7777), 32'h44c, 0, 0, 0, 0, 32'h0, 0, 0,
           ctrlWord(ALU_ADD, BR_NONE, WB_ALU, DST_RD, 6'b000001), 32'hffff_803f, 0);
    // flush beats write, nop held with old pc
    addRow(iType(OP_ADDIU, 1, 2, 16'h0001), 32'h450, 1, 1, 0, 0, 32'h0, 5, 1,
           ctrlWord(ALU_SLL, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0000_0000, 0);
    addRow(iType(OP_LW, 3, 18, 16'h0000), 32'h454, 0, 1, 0, 0, 32'h0, 3, 1,
           ctrlWord(ALU_ADD, BR_NONE, WB_MEM, DST_RT, 6'b110100), 32'h0000_0000, 1);
endtask

/* idStage_tb.sv */
module idStage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import idStagePkg::*;

    localparam logic [31:0] RESET_PC = 32'h0040_0000;
    localparam int RESET_CYCLES = 3;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        flush;
        logic        wr;
        logic        wbWe;
        logic [4:0]  wbDst;
        logic [31:0] wbRes;
        logic [4:0]  exeRt;
        logic        exeLoad;
        decodeCtrl_t ctrl;
        logic [31:0] imm;
        logic        stall;
    } caseRow_t;

    logic clk, rst, idFlush, idWr, wbRegWrite, exeIsLoad;
    logic [31:0] ifInstr, ifPc, wbResult;
    logic [4:0] wbDst, exeRt;
    logic [31:0] idInstr, idPc, idBusA, idBusB, idImm32;
    logic [4:0] idRs, idRt, idRd;
    decodeCtrl_t idCtrl;
    logic dhPcWr, dhIdWr, exeFlush;

    caseRow_t rows[$];
    logic [31:0] shadowRegs [32];  // expected register file contents
    logic [31:0] expInstr;
    logic [31:0] expPc;
    int cycleCount = 0;
    int cycleLimit = 0;

    idStage #(.RESET_PC(RESET_PC)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] rType(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [4:0] shamt, logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(logic [5:0] op, logic [25:0] target);
        return {op, target};
    endfunction

    // flag bits in order regWrite isLoad isStore aluSrcImm isImmJump reservedInstr
    function automatic decodeCtrl_t ctrlWord(aluOp_t a, branch_t b, wbSel_t w, dstSel_t d,
                                             logic [5:0] flags);
        decodeCtrl_t c;
        c.aluOp = a;
        c.branchType = b;
        c.wbSel = w;
        c.dstSel = d;
        {c.regWrite, c.isLoad, c.isStore, c.aluSrcImm, c.isImmJump, c.reservedInstr} = flags;
        return c;
    endfunction

    task automatic addRow(logic [31:0] instr, logic [31:0] pc, logic flush, logic wr,
                          logic wbWe, logic [4:0] dst, logic [31:0] res, logic [4:0] eRt,
                          logic eLoad, decodeCtrl_t ctrl, logic [31:0] imm, logic stall);
        caseRow_t r;
        r = '{instr, pc, flush, wr, wbWe, dst, res, eRt, eLoad, ctrl, imm, stall};
        rows.push_back(r);
    endtask

    `include "idStageCases.svh"

    task automatic checkVal(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, actual,
                     expected);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    // read port model with same-cycle writeback bypass
    function automatic logic [31:0] expectedRead(logic [4:0] idx);
        if (idx == 5'd0) return 32'h0;
        if (wbRegWrite && (wbDst == idx)) return wbResult;
        return shadowRegs[idx];
    endfunction

    // fetch side from row f and writeback/execute side from row e
    task automatic applyRow(int f, int e);
        if (f < rows.size()) begin
            ifInstr = rows[f].instr;
            ifPc = rows[f].pc;
            idFlush = rows[f].flush;
            idWr = rows[f].wr;
        end else begin
            idFlush = 1'b0;
            idWr = 1'b0;
        end
        if (e >= 0) begin
            wbRegWrite = rows[e].wbWe;
            wbDst = rows[e].wbDst;
            wbResult = rows[e].wbRes;
            exeRt = rows[e].exeRt;
            exeIsLoad = rows[e].exeLoad;
        end else begin
            wbRegWrite = 1'b0;
            wbDst = '0;
            wbResult = '0;
            exeRt = '0;
            exeIsLoad = 1'b0;
        end
    endtask

    // what the rising edge does to the stage
    task automatic updateModel();
        if (wbRegWrite && (wbDst != 5'd0)) shadowRegs[wbDst] = wbResult;
        if (idFlush) begin
            expInstr = NOP_INSTR;
        end else if (idWr) begin
            expInstr = ifInstr;
            expPc = ifPc;
        end
    endtask

    task automatic checkOutputs(decodeCtrl_t ctrl, logic [31:0] imm, logic stall);
        checkVal("idInstr", idInstr, expInstr);
        checkVal("idPc", idPc, expPc);
        checkVal("idRs", idRs, expInstr[25:21]);
        checkVal("idRt", idRt, expInstr[20:16]);
        checkVal("idRd", idRd, expInstr[15:11]);
        checkVal("idBusA", idBusA, expectedRead(expInstr[25:21]));
        checkVal("idBusB", idBusB, expectedRead(expInstr[20:16]));
        checkVal("idCtrl", idCtrl, ctrl);
        checkVal("idImm32", idImm32, imm);
        checkVal("dhPcWr", dhPcWr, !stall);
        checkVal("dhIdWr", dhIdWr, !stall);
        checkVal("exeFlush", exeFlush, stall);
    endtask

    initial begin
        rst = 1'b1;
        applyRow(1 << 30, -1);  // everything idle
        ifInstr = '0;
        ifPc = '0;
        for (int i = 0; i < 32; i++) shadowRegs[i] = '0;
        expInstr = NOP_INSTR;
        expPc = RESET_PC;
        loadCases();
        cycleLimit = rows.size() + RESET_CYCLES + 10;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
        #18;
        checkOutputs(ctrlWord(ALU_SLL, BR_NONE, WB_ALU, DST_RD, 6'b100000), 32'h0, 1'b0);
        for (int k = 0; k <= rows.size(); k++) begin
            @(posedge clk);
            updateModel();
            #2 applyRow(k, k - 1);
            #18;  // mid cycle where everything has settled
            if (k > 0) checkOutputs(rows[k - 1].ctrl, rows[k - 1].imm, rows[k - 1].stall);
        end
        $display("All tests passed!");
        $finish;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Test failures found");
            $fatal(1, "simulation ran past %0d cycles without finishing", cycleLimit);
        end
    end

endmodule

/* idStage.sv */
module idStage #(
    parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    idFlush,
    input  logic                    idWr,
    input  logic [31:0]             ifInstr,
    input  logic [31:0]             ifPc,
    input  logic [31:0]             wbResult,  // writeback into the register file
    input  logic [4:0]              wbDst,
    input  logic                    wbRegWrite,
    input  logic [4:0]              exeRt,
    input  logic                    exeIsLoad,
    output logic [31:0]             idInstr,
    output logic [31:0]             idPc,
    output logic [31:0]             idBusA,
    output logic [31:0]             idBusB,
    output logic [31:0]             idImm32,
    output logic [4:0]              idRs,
    output logic [4:0]              idRt,
    output logic [4:0]              idRd,
    output idStagePkg::decodeCtrl_t idCtrl,
    output logic                    dhPcWr,
    output logic                    dhIdWr,
    output logic                    exeFlush
);

    logic rsRead;
    logic rtRead;

    decodeBus idBus ();

    // fields leave the stage for execute and next-pc logic
    assign idInstr = idBus.instr;
    assign idPc    = idBus.pc;
    assign idRs    = idBus.rs;
    assign idRt    = idBus.rt;
    assign idRd    = idBus.rd;

    idPipeReg #(
        .RESET_PC (RESET_PC)
    ) uIdPipeReg (
        .clk     (clk),
        .rst     (rst),
        .flush   (idFlush),
        .wr      (idWr),
        .instrIn (ifInstr),
        .pcIn    (ifPc),
        .bus     (idBus)
    );

    regFile uRegFile (
        .clk        (clk),
        .rst        (rst),
        .bus        (idBus),
        .wbDst      (wbDst),
        .wbResult   (wbResult),
        .wbRegWrite (wbRegWrite),
        .busA       (idBusA),
        .busB       (idBusB)
    );

    instrDecoder uInstrDecoder (
        .bus    (idBus),
        .ctrl   (idCtrl),
        .imm32  (idImm32),
        .rsRead (rsRead),
        .rtRead (rtRead)
    );

    loadUseHazard uLoadUseHazard (
        .bus       (idBus),
        .rsRead    (rsRead),
        .rtRead    (rtRead),
        .exeRt     (exeRt),
        .exeIsLoad (exeIsLoad),
        .pcWr      (dhPcWr),
        .idWr      (dhIdWr),
        .exeFlush  (exeFlush)
    );

endmodule

/* loadUseHazard.sv */
module loadUseHazard (
    decodeBus.reader   bus,
    input  logic       rsRead,
    input  logic       rtRead,
    input  logic [4:0] exeRt,
    input  logic       exeIsLoad,
    output logic       pcWr,
    output logic       idWr,
    output logic       exeFlush
);

    logic loadPending;
    logic rsHit;
    logic rtHit;
    logic stall;

    // a load into $0 produces nothing to wait for
    assign loadPending = exeIsLoad && (exeRt != 5'd0);

    // only count fields the instruction really reads
    assign rsHit = rsRead && (bus.rs == exeRt);
    assign rtHit = rtRead && (bus.rt == exeRt);

    assign stall = loadPending && (rsHit || rtHit);

    assign pcWr     = !stall;  // hold fetch
    assign idWr     = !stall;  // hold decode
    assign exeFlush = stall;   // bubble into execute

endmodule

/* instrDecoder.sv */
module instrDecoder (
    decodeBus.reader                 bus,
    output idStagePkg::decodeCtrl_t  ctrl,
    output logic [31:0]              imm32,
    output logic                     rsRead,
    output logic                     rtRead
);
    import idStagePkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = bus.instr[31:26];
    assign funct  = bus.instr[5:0];
    assign imm16  = bus.instr[15:0];

    always_comb begin
        ctrl   = '0;  // add, no branch, alu result into rd
        rsRead = 1'b0;
        rtRead = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.dstSel   = DST_RD;
                rsRead        = 1'b1;
                rtRead        = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLL: begin
                        ctrl.aluOp = ALU_SLL;  // shamt taken from instr
                        rsRead     = 1'b0;
                    end
                    default: begin
                        ctrl.regWrite      = 1'b0;
                        ctrl.reservedInstr = 1'b1;
                        rsRead             = 1'b0;
                        rtRead             = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.dstSel    = DST_RT;
                ctrl.aluSrcImm = 1'b1;
                rsRead         = 1'b1;
                if (opcode == OP_ANDI) begin
                    ctrl.aluOp = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    ctrl.aluOp = ALU_OR;
                end else begin
                    ctrl.aluOp = ALU_ADD;
                end
            end
            OP_LUI: begin
                ctrl.aluOp     = ALU_LUI;
                ctrl.regWrite  = 1'b1;
                ctrl.dstSel    = DST_RT;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_LW: begin
                ctrl.aluOp     = ALU_ADD;  // base + offset
                ctrl.regWrite  = 1'b1;
                ctrl.isLoad    = 1'b1;
                ctrl.wbSel     = WB_MEM;
                ctrl.dstSel    = DST_RT;
                ctrl.aluSrcImm = 1'b1;
                rsRead         = 1'b1;
            end
            OP_SW: begin
                ctrl.aluOp     = ALU_ADD;
                ctrl.isStore   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                rsRead         = 1'b1;
                rtRead         = 1'b1;  // store data
            end
            OP_BEQ, OP_BNE: begin
                ctrl.aluOp      = ALU_SUB;  // compare rs against rt
                ctrl.branchType = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                rsRead          = 1'b1;
                rtRead          = 1'b1;
            end
            OP_J: begin
                ctrl.isImmJump = 1'b1;
            end
            OP_JAL: begin
                ctrl.isImmJump = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.wbSel     = WB_PC8;
                ctrl.dstSel    = DST_R31;  // link register
            end
            default: begin
                ctrl.reservedInstr = 1'b1;
            end
        endcase
    end

    // immediate extension
    always_comb begin
        case (opcode)
            OP_ANDI, OP_ORI: imm32 = {16'h0000, imm16};  // logical ops zero extend
            OP_LUI:          imm32 = {imm16, 16'h0000};
            default:         imm32 = {{16{imm16[15]}}, imm16};
        endcase
    end

endmodule

/* regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        rst,
    decodeBus.reader    bus,
    input  logic [4:0]  wbDst,
    input  logic [31:0] wbResult,
    input  logic        wbRegWrite,
    output logic [31:0] busA,
    output logic [31:0] busB
);

    logic [31:0] regs [32];
    logic        wrValid;

    // $0 is never written
    assign wrValid = wbRegWrite && (wbDst != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrValid) begin
            regs[wbDst] <= wbResult;
        end
    end

    // port A, rs
    always_comb begin
        if (bus.rs == 5'd0) begin
            busA = '0;
        end else if (wrValid && (wbDst == bus.rs)) begin
            busA = wbResult;  // writeback bypass
        end else begin
            busA = regs[bus.rs];
        end
    end

    // port B, rt
    always_comb begin
        if (bus.rt == 5'd0) begin
            busB = '0;
        end else if (wrValid && (wbDst == bus.rt)) begin
            busB = wbResult;  // writeback bypass
        end else begin
            busB = regs[bus.rt];
        end
    end

endmodule

/* idPipeReg.sv */
module idPipeReg #(
    parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        wr,
    input  logic [31:0] instrIn,
    input  logic [31:0] pcIn,
    decodeBus.regOut    bus
);
    import idStagePkg::*;

    logic [31:0] instrQ;
    logic [31:0] pcQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            instrQ <= NOP_INSTR;
            pcQ    <= RESET_PC;
        end else if (flush) begin
            // bubble keeps its pc
            instrQ <= NOP_INSTR;
        end else if (wr) begin
            instrQ <= instrIn;
            pcQ    <= pcIn;
        end
    end

    assign bus.instr = instrQ;
    assign bus.pc    = pcQ;

    // register fields, same position for every format
    assign bus.rs = instrQ[25:21];
    assign bus.rt = instrQ[20:16];
    assign bus.rd = instrQ[15:11];

endmodule

/* decodeBus.sv */
interface decodeBus;

    logic [31:0] instr;  // instruction held in decode
    logic [31:0] pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;

    // driven by the pipeline register
    modport regOut (
        output instr, pc, rs, rt, rd
    );

    // decoder, register file, hazard unit
    modport reader (
        input instr, pc, rs, rt, rd
    );

endinterface

/* idStagePkg.sv */
package idStagePkg;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDIU = 6'b001001;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // function field of R-type, instr[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0000;  // sll $0, $0, 0

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_SLL = 3'd5,
        ALU_LUI = 3'd6   // passes operand B through
    } aluOp_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ   = 2'd1,
        BR_NE   = 2'd2
    } branch_t;

    // source of the writeback value
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC8 = 2'd2    // link address for jal
    } wbSel_t;

    // which field names the destination register
    typedef enum logic [1:0] {
        DST_RD  = 2'd0,
        DST_RT  = 2'd1,
        DST_R31 = 2'd2
    } dstSel_t;

    // control bundle handed to execute
    typedef struct packed {
        aluOp_t  aluOp;
        branch_t branchType;
        wbSel_t  wbSel;
        dstSel_t dstSel;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        logic    aluSrcImm;      // operand B from imm32
        logic    isImmJump;      // j / jal, target from instr index
        logic    reservedInstr;
    } decodeCtrl_t;

endpackage
